// ==== predict_config.svh ====
//////////////////////////////
// Branch predictor sizing
// PC width, tag range and table index widths
//////////////////////////////

`ifndef PREDICT_CONFIG_SVH
`define PREDICT_CONFIG_SVH

// Instruction address width
`define PC_WIDTH 32

// Byte offset bits below the word boundary
// Never part of index or tag
`define PC_OFFSET_BITS 2

// Top PC bit seen by either table
`define PC_HIGH_BIT 15

// Index width for 16 target buffer sets
`define BTB_INDEX_BITS 4

// Index width for 64 direction counters
`define BHT_INDEX_BITS 6

`endif

// ==== fetch_pkg.sv ====
//////////////////////////////
// Fetch address types
// PC, index and tag slices shared by the predictor tables
//////////////////////////////

`include "predict_config.svh"

package fetch_pkg;

   typedef logic [`PC_WIDTH-1:0] pc_t;
   typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t;
   typedef logic [`PC_HIGH_BIT-`BTB_INDEX_BITS-`PC_OFFSET_BITS:0] btb_tag_t;
   typedef logic [`BHT_INDEX_BITS-1:0] bht_index_t;

   // Set index sits right above the word offset
   function automatic btb_index_t btb_index_of(pc_t pc);
      return pc[`BTB_INDEX_BITS+`PC_OFFSET_BITS-1:`PC_OFFSET_BITS];
   endfunction

   // Tag is the rest up to the top PC bit
   function automatic btb_tag_t btb_tag_of(pc_t pc);
      return pc[`PC_HIGH_BIT:`BTB_INDEX_BITS+`PC_OFFSET_BITS];
   endfunction

   function automatic bht_index_t bht_index_of(pc_t pc);
      return pc[`BHT_INDEX_BITS+`PC_OFFSET_BITS-1:`PC_OFFSET_BITS];
   endfunction

endpackage

// ==== predict_pkg.sv ====
//////////////////////////////
// Prediction state types
// Direction counter and way number
//////////////////////////////

package predict_pkg;

   // Top bit of the counter is the taken prediction
   typedef enum logic [1:0] {
      strong_not_taken = 2'b00,
      weak_not_taken   = 2'b01,
      weak_taken       = 2'b10,
      strong_taken     = 2'b11
   } counter_t;

   typedef enum logic {
      way_0 = 1'b0,
      way_1 = 1'b1
   } way_t;

   // One step toward the resolved direction, saturating at both ends
   function automatic counter_t counter_step(counter_t count, logic taken);
      if (taken) begin
         return (count == strong_taken) ? strong_taken : counter_t'(count + 2'd1);
      end
      return (count == strong_not_taken) ? strong_not_taken : counter_t'(count - 2'd1);
   endfunction

   function automatic way_t other_way(way_t way);
      return (way == way_0) ? way_1 : way_0;
   endfunction

endpackage

// ==== branch_target_buffer.sv ====
//////////////////////////////
// Branch target buffer
// Two-way tagged target store, LRU per set, two write ports
//////////////////////////////

`timescale 1ns/1ps

`include "predict_config.svh"

module branch_target_buffer (
   input  logic           clock,
   input  logic           reset,
   input  logic           lookup_en,
   input  fetch_pkg::pc_t lookup_pc,
   input  logic           write_en_0,
   input  fetch_pkg::pc_t write_pc_0,
   input  fetch_pkg::pc_t write_target_0,
   input  logic           write_en_1,
   input  fetch_pkg::pc_t write_pc_1,
   input  fetch_pkg::pc_t write_target_1,
   output logic           hit,
   output fetch_pkg::pc_t target
);

   localparam int SETS = 1 << `BTB_INDEX_BITS;

   // Storage, indexed [way][set]
   logic                valid   [2][SETS];
   fetch_pkg::btb_tag_t tags    [2][SETS];
   fetch_pkg::pc_t      targets [2][SETS];

   // LRU names the way to evict next
   predict_pkg::way_t lru      [SETS];
   predict_pkg::way_t lru_next [SETS];

   fetch_pkg::btb_index_t lookup_index;
   fetch_pkg::btb_tag_t   lookup_tag;
   logic [1:0]            lookup_match;

   // Write ports gathered for looping
   logic                  wr_accept [2];
   fetch_pkg::btb_index_t wr_index  [2];
   fetch_pkg::btb_tag_t   wr_tag    [2];
   fetch_pkg::pc_t        wr_target [2];
   predict_pkg::way_t     wr_way    [2];

   //////////////////////////////
   // Lookup
   //////////////////////////////

   assign lookup_index = fetch_pkg::btb_index_of(lookup_pc);
   assign lookup_tag   = fetch_pkg::btb_tag_of(lookup_pc);

   always_comb begin
      for (int w = 0; w < 2; w++) begin
         lookup_match[w] = lookup_en && valid[w][lookup_index] &&
                           (tags[w][lookup_index] == lookup_tag);
      end
   end

   assign hit    = |lookup_match;
   assign target = lookup_match[0] ? targets[0][lookup_index] :
                   lookup_match[1] ? targets[1][lookup_index] : '0;

   //////////////////////////////
   // Write way selection
   //////////////////////////////

   assign wr_index[0]  = fetch_pkg::btb_index_of(write_pc_0);
   assign wr_index[1]  = fetch_pkg::btb_index_of(write_pc_1);
   assign wr_tag[0]    = fetch_pkg::btb_tag_of(write_pc_0);
   assign wr_tag[1]    = fetch_pkg::btb_tag_of(write_pc_1);
   assign wr_target[0] = write_target_0;
   assign wr_target[1] = write_target_1;

   // Port 0 owns the set when both ports land on it
   assign wr_accept[0] = write_en_0;
   assign wr_accept[1] = write_en_1 && !(write_en_0 && (wr_index[1] == wr_index[0]));

   // Matching way first, then a free way, then the LRU victim
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         if (valid[0][wr_index[p]] && (tags[0][wr_index[p]] == wr_tag[p])) begin
            wr_way[p] = predict_pkg::way_0;
         end else if (valid[1][wr_index[p]] && (tags[1][wr_index[p]] == wr_tag[p])) begin
            wr_way[p] = predict_pkg::way_1;
         end else if (!valid[0][wr_index[p]]) begin
            wr_way[p] = predict_pkg::way_0;
         end else if (!valid[1][wr_index[p]]) begin
            wr_way[p] = predict_pkg::way_1;
         end else begin
            wr_way[p] = lru[wr_index[p]];
         end
      end
   end

   // Lookup hit first, writes after so they win on a shared set
   always_comb begin
      lru_next = lru;
      if (lookup_match[0]) begin
         lru_next[lookup_index] = predict_pkg::way_1;
      end else if (lookup_match[1]) begin
         lru_next[lookup_index] = predict_pkg::way_0;
      end
      for (int p = 0; p < 2; p++) begin
         if (wr_accept[p]) begin
            lru_next[wr_index[p]] = predict_pkg::other_way(wr_way[p]);
         end
      end
   end

   //////////////////////////////
   // State
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int s = 0; s < SETS; s++) begin
            valid[0][s] <= 1'b0;
            valid[1][s] <= 1'b0;
            lru[s]      <= predict_pkg::way_0;
         end
      end else begin
         lru <= lru_next;
         for (int p = 0; p < 2; p++) begin
            if (wr_accept[p]) begin
               valid[wr_way[p]][wr_index[p]] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      for (int p = 0; p < 2; p++) begin
         if (wr_accept[p]) begin
            tags[wr_way[p]][wr_index[p]]    <= wr_tag[p];
            targets[wr_way[p]][wr_index[p]] <= wr_target[p];
         end
      end
   end

endmodule

// ==== direction_table.sv ====
//////////////////////////////
// Direction table
// Direct-mapped 2-bit saturating counters
//////////////////////////////

`timescale 1ns/1ps

`include "predict_config.svh"

module direction_table (
   input  logic           clock,
   input  logic           reset,
   input  logic           lookup_en,
   input  fetch_pkg::pc_t lookup_pc,
   input  logic           update_en_0,
   input  fetch_pkg::pc_t update_pc_0,
   input  logic           update_taken_0,
   input  logic           update_en_1,
   input  fetch_pkg::pc_t update_pc_1,
   input  logic           update_taken_1,
   output logic           taken
);

   localparam int ENTRIES = 1 << `BHT_INDEX_BITS;

   predict_pkg::counter_t counters [ENTRIES];

   fetch_pkg::bht_index_t lookup_index;
   fetch_pkg::bht_index_t update_index_0;
   fetch_pkg::bht_index_t update_index_1;
   logic                  accept_1;

   assign lookup_index   = fetch_pkg::bht_index_of(lookup_pc);
   assign update_index_0 = fetch_pkg::bht_index_of(update_pc_0);
   assign update_index_1 = fetch_pkg::bht_index_of(update_pc_1);

   // Prediction is the counter's top bit
   assign taken = lookup_en && counters[lookup_index][1];

   // Port 1 drops out when port 0 trains the same counter
   assign accept_1 = update_en_1 && !(update_en_0 && (update_index_1 == update_index_0));

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < ENTRIES; i++) begin
            counters[i] <= predict_pkg::weak_not_taken;
         end
      end else begin
         if (update_en_0) begin
            counters[update_index_0] <=
               predict_pkg::counter_step(counters[update_index_0], update_taken_0);
         end
         if (accept_1) begin
            counters[update_index_1] <=
               predict_pkg::counter_step(counters[update_index_1], update_taken_1);
         end
      end
   end

endmodule

// ==== next_pc_select.sv ====
//////////////////////////////
// Next PC select
// Picks the buffer target or the fall-through address
//////////////////////////////

`timescale 1ns/1ps

module next_pc_select (
   input  fetch_pkg::pc_t lookup_pc,
   input  logic           hit,
   input  fetch_pkg::pc_t target,
   input  logic           taken,
   output fetch_pkg::pc_t predicted_pc,
   output logic           predicted_taken,
   output logic           target_hit
);

   // One instruction is four bytes
   localparam fetch_pkg::pc_t INSTR_BYTES = fetch_pkg::pc_t'(4);

   fetch_pkg::pc_t fall_through;

   assign fall_through = lookup_pc + INSTR_BYTES;

   // Redirect needs both a known target and a taken counter
   assign predicted_taken = hit && taken;
   assign predicted_pc    = predicted_taken ? target : fall_through;

   assign target_hit = hit;

endmodule

// ==== branch_predictor.sv ====
//////////////////////////////
// Branch predictor top
// Target buffer and direction table feeding the next PC select
//////////////////////////////

`timescale 1ns/1ps

module branch_predictor (
   input  logic           clock,
   input  logic           reset,
   input  logic           lookup_en,
   input  fetch_pkg::pc_t lookup_pc,
   input  logic           update_en_0,
   input  fetch_pkg::pc_t update_pc_0,
   input  fetch_pkg::pc_t update_target_0,
   input  logic           update_taken_0,
   input  logic           update_en_1,
   input  fetch_pkg::pc_t update_pc_1,
   input  fetch_pkg::pc_t update_target_1,
   input  logic           update_taken_1,
   output fetch_pkg::pc_t predicted_pc,
   output logic           predicted_taken,
   output logic           target_hit
);

   logic           btb_hit;
   fetch_pkg::pc_t btb_target;
   logic           bht_taken;

   // Every resolved branch records its target
   branch_target_buffer btb (
      .clock          (clock),
      .reset          (reset),
      .lookup_en      (lookup_en),
      .lookup_pc      (lookup_pc),
      .write_en_0     (update_en_0),
      .write_pc_0     (update_pc_0),
      .write_target_0 (update_target_0),
      .write_en_1     (update_en_1),
      .write_pc_1     (update_pc_1),
      .write_target_1 (update_target_1),
      .hit            (btb_hit),
      .target         (btb_target)
   );

   direction_table bht (
      .clock          (clock),
      .reset          (reset),
      .lookup_en      (lookup_en),
      .lookup_pc      (lookup_pc),
      .update_en_0    (update_en_0),
      .update_pc_0    (update_pc_0),
      .update_taken_0 (update_taken_0),
      .update_en_1    (update_en_1),
      .update_pc_1    (update_pc_1),
      .update_taken_1 (update_taken_1),
      .taken          (bht_taken)
   );

   next_pc_select select (
      .lookup_pc       (lookup_pc),
      .hit             (btb_hit),
      .target          (btb_target),
      .taken           (bht_taken),
      .predicted_pc    (predicted_pc),
      .predicted_taken (predicted_taken),
      .target_hit      (target_hit)
   );

endmodule

// ==== branch_predictor_tb.sv ====
//////////////////////////////
// Branch predictor testbench
// Directed and random tests checked against a table model
//////////////////////////////

`timescale 1ns/1ps

`include "predict_config.svh"

module branch_predictor_tb;

   localparam int SETS     = 1 << `BTB_INDEX_BITS;
   localparam int COUNTERS = 1 << `BHT_INDEX_BITS;

   logic           clock = 1'b0;
   logic           reset;
   logic           lookup_en;
   fetch_pkg::pc_t lookup_pc;
   logic           update_en_0;
   fetch_pkg::pc_t update_pc_0;
   fetch_pkg::pc_t update_target_0;
   logic           update_taken_0;
   logic           update_en_1;
   fetch_pkg::pc_t update_pc_1;
   fetch_pkg::pc_t update_target_1;
   logic           update_taken_1;
   fetch_pkg::pc_t predicted_pc;
   logic           predicted_taken;
   logic           target_hit;

   // Reference model of both tables
   // Model LRU holds the way to evict
   bit             ref_valid  [2][SETS];
   fetch_pkg::pc_t ref_tag    [2][SETS];
   fetch_pkg::pc_t ref_target [2][SETS];
   int             ref_lru    [SETS];
   int             ref_count  [COUNTERS];

   // Stimulus for the next cycle
   bit             stim_lookup_en;
   fetch_pkg::pc_t stim_lookup_pc;
   bit             stim_en     [2];
   fetch_pkg::pc_t stim_pc     [2];
   fetch_pkg::pc_t stim_target [2];
   bit             stim_taken  [2];

   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     test_start_errors = 0;
   string  test_name;
   integer seed = 32'h97a393f8;

   branch_predictor uut (
      .clock           (clock),
      .reset           (reset),
      .lookup_en       (lookup_en),
      .lookup_pc       (lookup_pc),
      .update_en_0     (update_en_0),
      .update_pc_0     (update_pc_0),
      .update_target_0 (update_target_0),
      .update_taken_0  (update_taken_0),
      .update_en_1     (update_en_1),
      .update_pc_1     (update_pc_1),
      .update_target_1 (update_target_1),
      .update_taken_1  (update_taken_1),
      .predicted_pc    (predicted_pc),
      .predicted_taken (predicted_taken),
      .target_hit      (target_hit)
   );

   always #4 clock = ~clock;

   //////////////////////////////
   // Model
   //////////////////////////////

   function automatic int set_of(input fetch_pkg::pc_t pc);
      return int'(pc[`BTB_INDEX_BITS+`PC_OFFSET_BITS-1:`PC_OFFSET_BITS]);
   endfunction

   function automatic fetch_pkg::pc_t tag_of(input fetch_pkg::pc_t pc);
      return 32'(pc[`PC_HIGH_BIT:`BTB_INDEX_BITS+`PC_OFFSET_BITS]);
   endfunction

   function automatic int counter_of(input fetch_pkg::pc_t pc);
      return int'(pc[`BHT_INDEX_BITS+`PC_OFFSET_BITS-1:`PC_OFFSET_BITS]);
   endfunction

   // Way 0 wins if both ways hold the tag
   function automatic bit find_way(input fetch_pkg::pc_t pc, output int way);
      int s;
      s = set_of(pc);
      way = 0;
      for (int w = 1; w >= 0; w--) begin
         if (ref_valid[w][s] && ref_tag[w][s] == tag_of(pc)) begin
            way = w;
         end
      end
      return ref_valid[way][s] && ref_tag[way][s] == tag_of(pc);
   endfunction

   function automatic int choose_way(input fetch_pkg::pc_t pc);
      int s;
      int w;
      s = set_of(pc);
      if (find_way(pc, w)) begin
         return w;
      end
      if (!ref_valid[0][s]) begin
         return 0;
      end
      if (!ref_valid[1][s]) begin
         return 1;
      end
      return ref_lru[s];
   endfunction

   function automatic int saturate_step(input int count, input bit taken);
      if (taken) begin
         return (count == 3) ? 3 : count + 1;
      end
      return (count == 0) ? 0 : count - 1;
   endfunction

   function automatic void clear_model();
      for (int s = 0; s < SETS; s++) begin
         ref_valid[0][s] = 1'b0;
         ref_valid[1][s] = 1'b0;
         ref_lru[s] = 0;
      end
      for (int i = 0; i < COUNTERS; i++) begin
         ref_count[i] = 1;
      end
   endfunction

   // State change at the clock edge that ends the current cycle
   function automatic void model_step();
      int ways [2];
      int sets [2];
      bit accept [2];
      int lk_way;
      int c0;
      int c1;
      for (int p = 0; p < 2; p++) begin
         sets[p] = set_of(stim_pc[p]);
         ways[p] = choose_way(stim_pc[p]);
      end
      accept[0] = stim_en[0];
      accept[1] = stim_en[1] && !(stim_en[0] && sets[1] == sets[0]);
      if (find_way(stim_lookup_pc, lk_way) && stim_lookup_en) begin
         ref_lru[set_of(stim_lookup_pc)] = 1 - lk_way;
      end
      for (int p = 0; p < 2; p++) begin
         if (accept[p]) begin
            ref_lru[sets[p]] = 1 - ways[p];
            ref_valid[ways[p]][sets[p]] = 1'b1;
            ref_tag[ways[p]][sets[p]] = tag_of(stim_pc[p]);
            ref_target[ways[p]][sets[p]] = stim_target[p];
         end
      end
      c0 = counter_of(stim_pc[0]);
      c1 = counter_of(stim_pc[1]);
      if (stim_en[0]) begin
         ref_count[c0] = saturate_step(ref_count[c0], stim_taken[0]);
      end
      if (stim_en[1] && !(stim_en[0] && c1 == c0)) begin
         ref_count[c1] = saturate_step(ref_count[c1], stim_taken[1]);
      end
   endfunction

   //////////////////////////////
   // Drive and check
   //////////////////////////////

   task automatic check_value(input string what, input fetch_pkg::pc_t expected,
                              input fetch_pkg::pc_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("[ERROR] %s %s expected %h actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic wait_level(input logic level);
      int n;
      n = 0;
      @(clock);
      while (clock !== level && n < 4) begin
         @(clock);
         n++;
      end
      if (clock !== level) begin
         $display("Timeout: clock did not reach level %b", level);
         errors++;
      end
   endtask

   // Drive on the rising edge and check on the falling edge
   task automatic run_cycle();
      int             way;
      bit             exp_hit;
      bit             exp_taken;
      fetch_pkg::pc_t exp_target;
      fetch_pkg::pc_t exp_pc;
      wait_level(1'b1);
      lookup_en       <= stim_lookup_en;
      lookup_pc       <= stim_lookup_pc;
      update_en_0     <= stim_en[0];
      update_pc_0     <= stim_pc[0];
      update_target_0 <= stim_target[0];
      update_taken_0  <= stim_taken[0];
      update_en_1     <= stim_en[1];
      update_pc_1     <= stim_pc[1];
      update_target_1 <= stim_target[1];
      update_taken_1  <= stim_taken[1];
      wait_level(1'b0);
      exp_hit    = find_way(stim_lookup_pc, way) && stim_lookup_en;
      exp_target = exp_hit ? ref_target[way][set_of(stim_lookup_pc)] : '0;
      exp_taken  = exp_hit && (ref_count[counter_of(stim_lookup_pc)] >= 2);
      exp_pc     = exp_taken ? exp_target : stim_lookup_pc + 32'd4;
      check_value("target_hit", 32'(exp_hit), 32'(target_hit));
      check_value("predicted_taken", 32'(exp_taken), 32'(predicted_taken));
      check_value("predicted_pc", exp_pc, predicted_pc);
      model_step();
      stim_lookup_en = 1'b0;
      stim_en[0] = 1'b0;
      stim_en[1] = 1'b0;
   endtask

   task automatic lookup_at(input fetch_pkg::pc_t pc, input bit enable);
      stim_lookup_en = enable;
      stim_lookup_pc = pc;
      run_cycle();
   endtask

   task automatic update_at(input fetch_pkg::pc_t pc, input fetch_pkg::pc_t target,
                            input bit taken);
      stim_en[0] = 1'b1;
      stim_pc[0] = pc;
      stim_target[0] = target;
      stim_taken[0] = taken;
      run_cycle();
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("Test %s finished with %0d errors", test_name, errors - test_start_errors);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic reset_state_test();
      begin_test("reset_state");
      for (int i = 0; i < 4; i++) begin
         lookup_at(32'h0000_1000 + 32'(i * 68), 1'b1);
      end
      update_at(32'h0000_1230, 32'h0000_2000, 1'b1);
      lookup_at(32'h0000_1230, 1'b0);
      check_value("disabled_hit", '0, 32'(target_hit));
      end_test();
   endtask

   task automatic training_test();
      begin_test("training");
      update_at(32'h0000_3008, 32'h0000_3800, 1'b1);
      lookup_at(32'h0000_3008, 1'b1);
      check_value("first_taken", 32'd1, 32'(predicted_taken));
      update_at(32'h0000_3008, 32'h0000_3800, 1'b0);
      update_at(32'h0000_3008, 32'h0000_3800, 1'b0);
      lookup_at(32'h0000_3008, 1'b1);
      check_value("trained_not_taken", '0, 32'(predicted_taken));
      check_value("still_hit", 32'd1, 32'(target_hit));
      for (int i = 0; i < 4; i++) begin
         update_at(32'h0000_3008, 32'h0000_3800, 1'b1);
      end
      update_at(32'h0000_3008, 32'h0000_3800, 1'b0);
      lookup_at(32'h0000_3008, 1'b1);
      check_value("saturated_taken", 32'd1, 32'(predicted_taken));
      end_test();
   endtask

   // Three tags in one set
   // Optional touch of the oldest entry before the third write
   task automatic replacement_round(input fetch_pkg::pc_t base, input bit touch_first);
      update_at(base, 32'h0000_7000, 1'b1);
      update_at(base + 32'h400, 32'h0000_7100, 1'b1);
      if (touch_first) begin
         lookup_at(base, 1'b1);
      end
      update_at(base + 32'h800, 32'h0000_7200, 1'b1);
      lookup_at(touch_first ? base + 32'h400 : base, 1'b1);
      check_value("evicted_hit", '0, 32'(target_hit));
      for (int k = 0; k < 3; k++) begin
         lookup_at(base + 32'(k * 32'h400), 1'b1);
      end
   endtask

   task automatic replacement_test();
      begin_test("replacement");
      replacement_round(32'h0000_0014, 1'b0);
      replacement_round(32'h0000_0018, 1'b1);
      end_test();
   endtask

   task automatic dual_update_test();
      begin_test("dual_update");
      stim_en     = '{1'b1, 1'b1};
      stim_pc     = '{32'h0000_5020, 32'h0000_5024};
      stim_target = '{32'h0000_5500, 32'h0000_5600};
      stim_taken  = '{1'b1, 1'b1};
      run_cycle();
      lookup_at(32'h0000_5020, 1'b1);
      lookup_at(32'h0000_5024, 1'b1);
      stim_en     = '{1'b1, 1'b1};
      stim_pc     = '{32'h0000_5028, 32'h0000_5428};
      stim_target = '{32'h0000_5700, 32'h0000_5800};
      run_cycle();
      lookup_at(32'h0000_5428, 1'b1);
      check_value("port_1_dropped", '0, 32'(target_hit));
      lookup_at(32'h0000_5028, 1'b1);
      end_test();
   endtask

   task automatic random_test();
      fetch_pkg::pc_t pool [12];
      logic [31:0]    rnd;
      begin_test("random_traffic");
      for (int i = 0; i < 12; i++) begin
         pool[i] = 32'h0000_6000 + 32'((i % 4) * 4 + (i / 4) * 256);
      end
      for (int n = 0; n < 200; n++) begin
         rnd = $random(seed);
         stim_lookup_en = rnd[1:0] != 2'b00;
         stim_lookup_pc = pool[int'(rnd[7:4]) % 12];
         for (int p = 0; p < 2; p++) begin
            rnd = $random(seed);
            stim_en[p] = rnd[0];
            stim_taken[p] = rnd[1];
            stim_pc[p] = pool[int'(rnd[7:4]) % 12];
            stim_target[p] = {16'h0000, rnd[31:18], 2'b00};
         end
         run_cycle();
      end
      end_test();
   endtask

   initial begin
      reset           <= 1'b1;
      lookup_en       <= 1'b0;
      lookup_pc       <= '0;
      update_en_0     <= 1'b0;
      update_pc_0     <= '0;
      update_target_0 <= '0;
      update_taken_0  <= 1'b0;
      update_en_1     <= 1'b0;
      update_pc_1     <= '0;
      update_target_1 <= '0;
      update_taken_1  <= 1'b0;
      stim_pc     = '{32'h0, 32'h0};
      stim_target = '{32'h0, 32'h0};
      stim_taken  = '{1'b0, 1'b0};
      clear_model();
      wait_level(1'b1);
      wait_level(1'b1);
      reset <= 1'b0;
      reset_state_test();
      training_test();
      replacement_test();
      dual_update_test();
      random_test();
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog for a stalled run
   initial begin
      #20000;
      $display("Timeout: the tests did not complete within 20000 ns");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== branch_predictor.f ====
+incdir+.
fetch_pkg.sv
predict_pkg.sv
branch_target_buffer.sv
direction_table.sv
next_pc_select.sv
branch_predictor.sv
branch_predictor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f branch_predictor.f \
   --top-module branch_predictor_tb -o sim_branch_predictor > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_branch_predictor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
   exit 0
fi
exit 1
